// File: Makefile
# Verilator flow for the fight core

TOP := fight_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o fight_sim
	./obj_dir/fight_sim 2>&1 | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/fight_defs.svh
`ifndef FIGHT_DEFS_SVH
`define FIGHT_DEFS_SVH

// Movement and arena
`define FIGHT_SPEED        15
`define FIGHT_X_MIN        50
`define FIGHT_X_MAX        490
`define FIGHT_START_L      210
`define FIGHT_START_R      420
`define FIGHT_POS_Y        170

// Box offsets from the fighter's position
`define FIGHT_HIT_X1       37
`define FIGHT_HIT_X2       113
`define FIGHT_HIT_Y1       24
`define FIGHT_HIT_Y2       57
`define FIGHT_BODY_NEAR    37
`define FIGHT_BODY_FAR     86
`define FIGHT_SPRITE_W     150

`define FIGHT_START_LEN    5  // Cycles in each attack phase
`define FIGHT_ACTIVE_LEN   2
`define FIGHT_PULL_LEN     16

`define FIGHT_HEALTH_MAX   100
`define FIGHT_DAMAGE       10

`define FIGHT_REG_CTRL     8'h00
`define FIGHT_REG_LEFT     8'h04
`define FIGHT_REG_RIGHT    8'h08

`endif

// File: list.f
+incdir+include
src/fight_pkg.sv
src/fighter_if.sv
src/round_if.sv
src/fighter_fsm.sv
src/hit_judge.sv
src/health_keeper.sv
src/status_regs.sv
src/fight_top.sv
verif/fight_asserts.sv
verif/fight_tb.sv

// File: src/fight_pkg.sv
package fight_pkg;

  // Encodings are visible to host software through the status registers
  typedef enum logic [3:0] {
    idle       = 4'd0,
    move_fwd   = 4'd1,
    move_back  = 4'd2,
    atk_start  = 4'd3,
    atk_active = 4'd4, // Only phase where the attack box can land
    atk_pull   = 4'd5
  } fighter_state_e;

  // Inclusive rectangle, x1 <= x2 and y1 <= y2
  typedef struct packed {
    logic [9:0] x1;
    logic [9:0] x2;
    logic [9:0] y1;
    logic [9:0] y2;
  } box_t;

endpackage

// File: src/fight_top.sv
`timescale 1ns/1ps

module fight_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        left_l,
  input  logic        right_l,
  input  logic        attack_l,
  input  logic        left_r,
  input  logic        right_r,
  input  logic        attack_r,
  input  logic [7:0]  s_axil_awaddr,
  input  logic        s_axil_awvalid,
  output logic        s_axil_awready,
  input  logic [31:0] s_axil_wdata,
  input  logic [3:0]  s_axil_wstrb,
  input  logic        s_axil_wvalid,
  output logic        s_axil_wready,
  output logic [1:0]  s_axil_bresp,
  output logic        s_axil_bvalid,
  input  logic        s_axil_bready,
  input  logic [7:0]  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output logic [31:0] s_axil_rdata,
  output logic [1:0]  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready
);

  logic hit_on_l;
  logic hit_on_r;

  fighter_if fl ();
  fighter_if fr ();
  round_if   round ();

  fighter_fsm #(.SIDE(1'b0)) fighter_l (
    .clk(clk), .rst(rst), .left(left_l), .right(right_l), .attack(attack_l),
    .fighter(fl), .round(round)
  );

  fighter_fsm #(.SIDE(1'b1)) fighter_r (
    .clk(clk), .rst(rst), .left(left_r), .right(right_r), .attack(attack_r),
    .fighter(fr), .round(round)
  );

  hit_judge judge (
    .clk(clk), .rst(rst), .fl(fl), .fr(fr), .hit_on_l(hit_on_l), .hit_on_r(hit_on_r)
  );

  health_keeper keeper (
    .clk(clk), .rst(rst), .hit_on_l(hit_on_l), .hit_on_r(hit_on_r), .round(round)
  );

  status_regs regs (
    .clk(clk), .rst(rst),
    .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
    .s_axil_awready(s_axil_awready),
    .s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
    .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
    .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
    .s_axil_bready(s_axil_bready),
    .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
    .s_axil_arready(s_axil_arready),
    .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
    .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
    .fl(fl), .fr(fr), .round(round)
  );

endmodule

// File: src/fighter_fsm.sv
`timescale 1ns/1ps
`include "fight_defs.svh"

module fighter_fsm #(
  parameter bit SIDE = 1'b0 // 0 is the left fighter, 1 the right one
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       left,
  input  logic       right,
  input  logic       attack,
  fighter_if.source  fighter,
  round_if.fighter   round
);

  localparam logic [9:0] start_x = SIDE ? 10'(`FIGHT_START_R) : 10'(`FIGHT_START_L);
  localparam logic [9:0] pos_y   = 10'(`FIGHT_POS_Y);

  fight_pkg::fighter_state_e state;
  fight_pkg::fighter_state_e state_nx;
  logic [4:0]                phase_cnt;
  logic                      phase_done;
  logic [9:0]                posx;
  logic [9:0]                posx_step;
  logic [9:0]                posx_nx;
  fight_pkg::box_t           hit_box;
  fight_pkg::box_t           body_box;

  ////////////////////////////////////////
  // State and phase counter
  ////////////////////////////////////////

  always_comb begin
    case (state)
      fight_pkg::atk_start:  phase_done = (phase_cnt == 5'(`FIGHT_START_LEN - 1));
      fight_pkg::atk_active: phase_done = (phase_cnt == 5'(`FIGHT_ACTIVE_LEN - 1));
      fight_pkg::atk_pull:   phase_done = (phase_cnt == 5'(`FIGHT_PULL_LEN - 1));
      default:               phase_done = 1'b0;
    endcase
  end

  always_comb begin
    state_nx = state;
    case (state)
      fight_pkg::idle, fight_pkg::move_fwd, fight_pkg::move_back: begin
        if (attack) begin
          state_nx = fight_pkg::atk_start;
        end else if (left && right) begin
          state_nx = fight_pkg::move_back;
        end else if (left) begin
          state_nx = SIDE ? fight_pkg::move_fwd : fight_pkg::move_back;
        end else if (right) begin
          state_nx = SIDE ? fight_pkg::move_back : fight_pkg::move_fwd;
        end else begin
          state_nx = fight_pkg::idle;
        end
      end
      fight_pkg::atk_start:  if (phase_done) state_nx = fight_pkg::atk_active;
      fight_pkg::atk_active: if (phase_done) state_nx = fight_pkg::atk_pull;
      fight_pkg::atk_pull:   if (phase_done) state_nx = fight_pkg::idle;
      default:               state_nx = fight_pkg::idle;
    endcase
    if (round.round_over) state_nx = fight_pkg::idle; // Frozen after a knockout
  end

  ////////////////////////////////////////
  // Position, one step behind the state
  ////////////////////////////////////////

  always_comb begin
    case (state)
      fight_pkg::move_fwd:  posx_step = SIDE ? posx - 10'(`FIGHT_SPEED) : posx + 10'(`FIGHT_SPEED);
      fight_pkg::move_back: posx_step = SIDE ? posx + 10'(`FIGHT_SPEED) : posx - 10'(`FIGHT_SPEED);
      default:              posx_step = posx;
    endcase
    if (posx_step < 10'(`FIGHT_X_MIN)) begin
      posx_nx = 10'(`FIGHT_X_MIN);
    end else if (posx_step > 10'(`FIGHT_X_MAX)) begin
      posx_nx = 10'(`FIGHT_X_MAX);
    end else begin
      posx_nx = posx_step;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= fight_pkg::idle;
      phase_cnt <= '0;
      posx      <= start_x;
    end else if (round.restart) begin
      state     <= fight_pkg::idle;
      phase_cnt <= '0;
      posx      <= start_x;
    end else begin
      state     <= state_nx;
      phase_cnt <= (state_nx == state) ? phase_cnt + 5'd1 : 5'd0; // Restart on every change
      posx      <= posx_nx;
    end
  end

  // Body box is mirrored inside the sprite for the right fighter
  always_comb begin
    hit_box.x1  = posx + 10'(`FIGHT_HIT_X1);
    hit_box.x2  = posx + 10'(`FIGHT_HIT_X2);
    hit_box.y1  = pos_y + 10'(`FIGHT_HIT_Y1);
    hit_box.y2  = pos_y + 10'(`FIGHT_HIT_Y2);
    body_box.x1 = SIDE ? posx + 10'(`FIGHT_SPRITE_W - `FIGHT_BODY_FAR)
                       : posx + 10'(`FIGHT_BODY_NEAR);
    body_box.x2 = SIDE ? posx + 10'(`FIGHT_SPRITE_W - `FIGHT_BODY_NEAR)
                       : posx + 10'(`FIGHT_BODY_FAR);
    body_box.y1 = pos_y;
    body_box.y2 = pos_y + 10'(`FIGHT_SPRITE_W);
  end

  assign fighter.posx     = posx;
  assign fighter.state    = state;
  assign fighter.hit_box  = hit_box;
  assign fighter.body_box = body_box;

endmodule

// File: src/fighter_if.sv
`timescale 1ns/1ps

interface fighter_if;

  logic [9:0]                posx;
  fight_pkg::fighter_state_e state;
  fight_pkg::box_t           hit_box;  // Attack reach
  fight_pkg::box_t           body_box; // Area that can be hit

  modport source (
    output posx,
    output state,
    output hit_box,
    output body_box
  );

  modport judge (
    input state,
    input hit_box,
    input body_box
  );

  modport status (
    input posx,
    input state
  );

endinterface

// File: src/health_keeper.sv
`timescale 1ns/1ps
`include "fight_defs.svh"

module health_keeper (
  input  logic     clk,
  input  logic     rst,
  input  logic     hit_on_l,
  input  logic     hit_on_r,
  round_if.keeper  round
);

  localparam logic [6:0] damage     = 7'(`FIGHT_DAMAGE);
  localparam logic [6:0] health_max = 7'(`FIGHT_HEALTH_MAX);

  logic [6:0] health_l_nx;
  logic [6:0] health_r_nx;
  logic       knockout;

  // Damage saturates at zero
  always_comb begin
    health_l_nx = round.health_l;
    health_r_nx = round.health_r;
    if (hit_on_l) begin
      health_l_nx = (round.health_l > damage) ? round.health_l - damage : 7'd0;
    end
    if (hit_on_r) begin
      health_r_nx = (round.health_r > damage) ? round.health_r - damage : 7'd0;
    end
  end

  assign knockout = (health_l_nx == 7'd0) || (health_r_nx == 7'd0);

  ////////////////////////////////////////
  // Health and round result
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      round.health_l   <= health_max;
      round.health_r   <= health_max;
      round.round_over <= 1'b0;
      round.winner     <= 1'b0;
    end else if (round.restart) begin
      round.health_l   <= health_max;
      round.health_r   <= health_max;
      round.round_over <= 1'b0;
      round.winner     <= 1'b0;
    end else if (!round.round_over) begin
      round.health_l <= health_l_nx;
      round.health_r <= health_r_nx;
      if (knockout) begin
        round.round_over <= 1'b1;
        // A double knockout goes to the left fighter
        round.winner     <= (health_r_nx != 7'd0);
      end
    end
  end

endmodule

// File: src/hit_judge.sv
`timescale 1ns/1ps

module hit_judge (
  input  logic      clk,
  input  logic      rst,
  fighter_if.judge  fl,
  fighter_if.judge  fr,
  output logic      hit_on_l,
  output logic      hit_on_r
);

  logic landed_by_l; // Left's current attack has already scored
  logic landed_by_r;
  logic score_l;     // Left fighter gets hit this cycle
  logic score_r;

  // Inclusive overlap in both axes
  function automatic logic boxes_touch(input fight_pkg::box_t a, input fight_pkg::box_t b);
    boxes_touch = (a.x1 <= b.x2) && (b.x1 <= a.x2) && (a.y1 <= b.y2) && (b.y1 <= a.y2);
  endfunction

  assign score_r = (fl.state == fight_pkg::atk_active) && !landed_by_l
                   && boxes_touch(fl.hit_box, fr.body_box);
  assign score_l = (fr.state == fight_pkg::atk_active) && !landed_by_r
                   && boxes_touch(fr.hit_box, fl.body_box);

  ////////////////////////////////////////
  // One pulse per attack
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hit_on_l    <= 1'b0;
      hit_on_r    <= 1'b0;
      landed_by_l <= 1'b0;
      landed_by_r <= 1'b0;
    end else begin
      hit_on_l    <= score_l;
      hit_on_r    <= score_r;
      // Flag re-arms as soon as the attacker leaves the active phase
      landed_by_l <= (fl.state == fight_pkg::atk_active) && (landed_by_l || score_r);
      landed_by_r <= (fr.state == fight_pkg::atk_active) && (landed_by_r || score_l);
    end
  end

endmodule

// File: src/round_if.sv
`timescale 1ns/1ps

interface round_if;

  logic [6:0] health_l;
  logic [6:0] health_r;
  logic       round_over;
  logic       winner;  // Set when the right fighter won
  logic       restart; // Single-cycle pulse from the host

  modport keeper (
    output health_l, health_r, round_over, winner,
    input  restart
  );

  modport fighter (
    input round_over, restart
  );

  modport host (
    input  health_l, health_r, round_over, winner,
    output restart
  );

endinterface

// File: src/status_regs.sv
`timescale 1ns/1ps
`include "fight_defs.svh"

module status_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  s_axil_awaddr,
  input  logic        s_axil_awvalid,
  output logic        s_axil_awready,
  input  logic [31:0] s_axil_wdata,
  input  logic [3:0]  s_axil_wstrb,
  input  logic        s_axil_wvalid,
  output logic        s_axil_wready,
  output logic [1:0]  s_axil_bresp,
  output logic        s_axil_bvalid,
  input  logic        s_axil_bready,
  input  logic [7:0]  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output logic [31:0] s_axil_rdata,
  output logic [1:0]  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready,
  fighter_if.status   fl,
  fighter_if.status   fr,
  round_if.host       round
);

  logic        wr_go;   // Write address and data taken this cycle
  logic        rd_go;
  logic        ctrl_hit;
  logic [31:0] rd_word;

  function automatic logic [31:0] fighter_word(input logic [9:0] posx,
                                               input fight_pkg::fighter_state_e state,
                                               input logic [6:0] health);
    fighter_word = {9'd0, health, 4'(state), 2'd0, posx};
  endfunction

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign wr_go          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign rd_go          = s_axil_arvalid && !s_axil_rvalid;
  assign s_axil_awready = wr_go; // Address and data are taken together
  assign s_axil_wready  = wr_go;
  assign s_axil_arready = rd_go;
  assign s_axil_bresp   = 2'b00;
  assign s_axil_rresp   = 2'b00;

  assign ctrl_hit = (s_axil_awaddr == `FIGHT_REG_CTRL) && s_axil_wstrb[0] && s_axil_wdata[0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s_axil_bvalid <= 1'b0;
      s_axil_rvalid <= 1'b0;
      round.restart <= 1'b0;
    end else begin
      round.restart <= wr_go && ctrl_hit;
      if (wr_go) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (rd_go) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  always_comb begin
    case (s_axil_araddr)
      `FIGHT_REG_CTRL:  rd_word = {30'd0, round.winner, round.round_over};
      `FIGHT_REG_LEFT:  rd_word = fighter_word(fl.posx, fl.state, round.health_l);
      `FIGHT_REG_RIGHT: rd_word = fighter_word(fr.posx, fr.state, round.health_r);
      default:          rd_word = 32'd0;
    endcase
  end

  // Read data is captured at the handshake and holds under back-pressure
  always_ff @(posedge clk) begin
    if (rd_go) begin
      s_axil_rdata <= rd_word;
    end
  end

endmodule

// File: verif/fight_asserts.sv
`timescale 1ns/1ps
`include "fight_defs.svh"

module fight_asserts (
  input logic        clk,
  input logic        rst,
  input logic        hit_on_l,
  input logic        hit_on_r,
  input logic [9:0]  posx_l,
  input logic [9:0]  posx_r,
  input logic        s_axil_bvalid,
  input logic        s_axil_bready,
  input logic        s_axil_rvalid,
  input logic        s_axil_rready,
  input logic [31:0] s_axil_rdata
);

  int fail_count = 0; // Watched by the testbench

  ////////////////////////////////////////
  // Game rules
  ////////////////////////////////////////

  hit_l_one_cycle: assert property (@(posedge clk) disable iff (rst) hit_on_l |=> !hit_on_l)
    else begin
      fail_count++;
      $error("hit_on_l held longer than one cycle");
    end
  hit_r_one_cycle: assert property (@(posedge clk) disable iff (rst) hit_on_r |=> !hit_on_r)
    else begin
      fail_count++;
      $error("hit_on_r held longer than one cycle");
    end

  posx_l_range: assert property (@(posedge clk) disable iff (rst)
      posx_l >= 10'(`FIGHT_X_MIN) && posx_l <= 10'(`FIGHT_X_MAX))
    else begin
      fail_count++;
      $error("Left position left the arena");
    end
  posx_r_range: assert property (@(posedge clk) disable iff (rst)
      posx_r >= 10'(`FIGHT_X_MIN) && posx_r <= 10'(`FIGHT_X_MAX))
    else begin
      fail_count++;
      $error("Right position left the arena");
    end

  ////////////////////////////////////////
  // AXI response hold
  ////////////////////////////////////////

  bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end
  rvalid_hold: assert property (@(posedge clk) disable iff (rst)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else begin
      fail_count++;
      $error("Read response changed before rready");
    end

endmodule

bind fight_top fight_asserts fight_asserts_i (
  .clk(clk), .rst(rst), .hit_on_l(hit_on_l), .hit_on_r(hit_on_r),
  .posx_l(fl.posx), .posx_r(fr.posx),
  .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
  .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
  .s_axil_rdata(s_axil_rdata)
);

// File: verif/fight_tb.sv
`timescale 1ns/1ps
`include "fight_defs.svh"

module fight_tb;

  localparam int wait_limit = 200;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic left_l = 1'b0, right_l = 1'b0, attack_l = 1'b0;
  logic left_r = 1'b0, right_r = 1'b0, attack_r = 1'b0;
  logic [7:0]  s_axil_awaddr = '0, s_axil_araddr = '0;
  logic [31:0] s_axil_wdata = '0;
  logic [3:0]  s_axil_wstrb = '0;
  logic s_axil_awvalid = 1'b0, s_axil_wvalid = 1'b0, s_axil_bready = 1'b0;
  logic s_axil_arvalid = 1'b0, s_axil_rready = 1'b0;
  logic s_axil_awready, s_axil_wready, s_axil_bvalid, s_axil_arready, s_axil_rvalid;
  logic [1:0]  s_axil_bresp, s_axil_rresp;
  logic [31:0] s_axil_rdata;

  int seed = 32'hc3a912fa;
  int hits_r = 0;
  int exp_l;
  int exp_r;
  int hp_r;
  int hits_before;
  logic [31:0] rd;

  fight_top fight_top_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) if (fight_top_i.hit_on_r) hits_r <= hits_r + 1;

  always @(posedge clk) begin
    if (fight_top_i.fight_asserts_i.fail_count != 0) begin
      $display("An assertion in the bound checker failed");
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  task automatic give_up(input string what);
    $display("TIMEOUT: %s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // LEFT and RIGHT layout: posx 9:0, state 15:12, health 22:16
  function automatic logic [31:0] status_word(input int pos, input int st, input int hp);
    logic [31:0] w;
    w = '0;
    w[9:0]   = pos[9:0];
    w[15:12] = st[3:0];
    w[22:16] = hp[6:0];
    return w;
  endfunction

  function automatic int moved(input int pos, input int dir, input int n);
    for (int i = 0; i < n; i++) begin
      pos = pos + dir * `FIGHT_SPEED;
      if (pos < `FIGHT_X_MIN) pos = `FIGHT_X_MIN;
      if (pos > `FIGHT_X_MAX) pos = `FIGHT_X_MAX;
    end
    return pos;
  endfunction

  task automatic bus_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
    int cnt;
    cnt = 0;
    s_axil_araddr  <= addr;
    s_axil_arvalid <= 1'b1;
    @(posedge clk);
    while (!s_axil_arready) begin
      if (++cnt > wait_limit) give_up("read address was never accepted by the bus");
      @(posedge clk);
    end
    s_axil_arvalid <= 1'b0;
    s_axil_araddr  <= ~addr; // Address is free to change once taken
    repeat (hold) @(posedge clk); // Back-pressure on the read response
    s_axil_rready <= 1'b1;
    @(posedge clk);
    while (!(s_axil_rvalid && s_axil_rready)) begin
      if (++cnt > wait_limit) give_up("read data never came back from the bus");
      @(posedge clk);
    end
    data = s_axil_rdata;
    expect_eq("read response", 32'd0, 32'(s_axil_rresp));
    s_axil_rready <= 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    int cnt;
    cnt = 0;
    s_axil_awaddr  <= addr;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= 4'hf;
    s_axil_awvalid <= 1'b1;
    s_axil_wvalid  <= 1'b1;
    @(posedge clk);
    while (!(s_axil_awready && s_axil_wready)) begin
      if (++cnt > wait_limit) give_up("write was never accepted by the bus");
      @(posedge clk);
    end
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    @(posedge clk);
    while (!s_axil_bvalid) begin
      if (++cnt > wait_limit) give_up("write response never came back from the bus");
      @(posedge clk);
    end
    expect_eq("write response", 32'd0, 32'(s_axil_bresp));
    s_axil_bready <= 1'b1; // Response waits one cycle before it is taken
    @(posedge clk);
    s_axil_bready <= 1'b0;
  endtask

  task automatic press(input logic ll, input logic rl, input logic lr, input logic rr,
                       input int n);
    left_l  <= ll;
    right_l <= rl;
    left_r  <= lr;
    right_r <= rr;
    repeat (n) @(posedge clk);
    left_l  <= 1'b0;
    right_l <= 1'b0;
    left_r  <= 1'b0;
    right_r <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic wait_left_state(input fight_pkg::fighter_state_e st);
    int cnt;
    cnt = 0;
    while (fight_top_i.fl.state != st) begin
      if (++cnt > wait_limit) give_up("left fighter never reached the expected state");
      @(posedge clk);
    end
  endtask

  // Counts cycles spent in one attack phase
  task automatic measure_phase(input string name, input fight_pkg::fighter_state_e st,
                               input int len);
    int cnt;
    cnt = 0;
    while (fight_top_i.fl.state == st && cnt < wait_limit) begin
      cnt++;
      @(posedge clk);
    end
    expect_eq(name, len, cnt);
  endtask

  task automatic strike_left();
    attack_l <= 1'b1;
    @(posedge clk);
    attack_l <= 1'b0;
    @(posedge clk);
    wait_left_state(fight_pkg::idle);
    repeat (3) @(posedge clk);
  endtask

  task automatic strike_right();
    int cnt;
    cnt = 0;
    attack_r <= 1'b1;
    @(posedge clk);
    attack_r <= 1'b0;
    @(posedge clk);
    while (fight_top_i.fr.state != fight_pkg::idle) begin
      if (++cnt > wait_limit) give_up("right fighter never returned to idle");
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic check_fighters(input string name, input int hp_l_exp, input int hp_r_exp);
    bus_read(`FIGHT_REG_LEFT, 0, rd);
    expect_eq({name, " left"}, status_word(exp_l, 0, hp_l_exp), rd);
    bus_read(`FIGHT_REG_RIGHT, 0, rd);
    expect_eq({name, " right"}, status_word(exp_r, 0, hp_r_exp), rd);
  endtask

  initial begin
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // After reset
    exp_l = `FIGHT_START_L;
    exp_r = `FIGHT_START_R;
    check_fighters("reset", `FIGHT_HEALTH_MAX, `FIGHT_HEALTH_MAX);
    bus_read(`FIGHT_REG_CTRL, 0, rd);
    expect_eq("reset ctrl", 32'd0, rd);

    ////////////////////////////////////////
    // Movement and clamp
    ////////////////////////////////////////
    press(1'b0, 1'b1, 1'b0, 1'b0, 4);
    exp_l = moved(exp_l, 1, 4);
    press(1'b1, 1'b0, 1'b0, 1'b0, 20);
    exp_l = moved(exp_l, -1, 20);
    press(1'b0, 1'b1, 1'b0, 1'b0, 10);
    exp_l = moved(exp_l, 1, 10);
    press(1'b1, 1'b1, 1'b0, 1'b0, 2); // Both pressed moves back
    exp_l = moved(exp_l, -1, 2);
    press(1'b0, 1'b0, 1'b0, 1'b1, 6); // Right fighter backs away to the right
    exp_r = moved(exp_r, 1, 6);
    press(1'b0, 1'b0, 1'b1, 1'b0, 10);
    exp_r = moved(exp_r, -1, 10);
    check_fighters("movement", `FIGHT_HEALTH_MAX, `FIGHT_HEALTH_MAX);

    // Attack phases with movement held
    attack_l <= 1'b1;
    right_l  <= 1'b1;
    @(posedge clk);
    attack_l <= 1'b0;
    @(posedge clk);
    measure_phase("atk_start length", fight_pkg::atk_start, `FIGHT_START_LEN);
    measure_phase("atk_active length", fight_pkg::atk_active, `FIGHT_ACTIVE_LEN);
    right_l <= 1'b0;
    measure_phase("atk_pull length", fight_pkg::atk_pull, `FIGHT_PULL_LEN);
    expect_eq("after attack", 32'(fight_pkg::idle), 32'(fight_top_i.fl.state));
    check_fighters("attack no move", `FIGHT_HEALTH_MAX, `FIGHT_HEALTH_MAX);

    ////////////////////////////////////////
    // Hit, damage and knockout
    ////////////////////////////////////////
    strike_left(); // Out of range
    check_fighters("miss", `FIGHT_HEALTH_MAX, `FIGHT_HEALTH_MAX);
    while (exp_r - exp_l > 49) begin
      press(1'b0, 1'b1, 1'b1, 1'b0, 1);
      exp_l = moved(exp_l, 1, 1);
      exp_r = moved(exp_r, -1, 1);
    end
    hp_r = `FIGHT_HEALTH_MAX;
    for (int i = 0; i < 10; i++) begin
      hits_before = hits_r;
      strike_left();
      hp_r = hp_r - `FIGHT_DAMAGE;
      expect_eq("one hit per attack", hits_before + 1, hits_r);
      check_fighters("damage", `FIGHT_HEALTH_MAX, hp_r);
    end
    bus_read(`FIGHT_REG_CTRL, 0, rd);
    expect_eq("knockout ctrl", 32'd1, rd);
    attack_l <= 1'b1;
    press(1'b0, 1'b1, 1'b1, 1'b0, 5); // Frozen fighters ignore this
    attack_l <= 1'b0;
    check_fighters("frozen", `FIGHT_HEALTH_MAX, 0);

    ////////////////////////////////////////
    // Restart and bus
    ////////////////////////////////////////
    bus_write(`FIGHT_REG_CTRL, 32'd1);
    repeat (2) @(posedge clk);
    exp_l = `FIGHT_START_L;
    exp_r = `FIGHT_START_R;
    check_fighters("restart", `FIGHT_HEALTH_MAX, `FIGHT_HEALTH_MAX);
    bus_read(`FIGHT_REG_CTRL, 0, rd);
    expect_eq("restart ctrl", 32'd0, rd);
    for (int i = 0; i < 4; i++) begin
      bus_read(`FIGHT_REG_RIGHT, ($random(seed) & 7) + 1, rd);
      expect_eq("held read", status_word(exp_r, 0, `FIGHT_HEALTH_MAX), rd);
    end
    bus_write(8'h10, 32'hffff_ffff);
    bus_read(8'h10, 2, rd);
    expect_eq("unknown address", 32'd0, rd);

    // The right fighter lands one attack on the left
    while (exp_r - exp_l > 49) begin
      press(1'b0, 1'b1, 1'b1, 1'b0, 1);
      exp_l = moved(exp_l, 1, 1);
      exp_r = moved(exp_r, -1, 1);
    end
    strike_right();
    check_fighters("counter hit", `FIGHT_HEALTH_MAX - `FIGHT_DAMAGE, `FIGHT_HEALTH_MAX);

    repeat (3) @(posedge clk);
    if (fight_top_i.fight_asserts_i.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  initial begin
    #1ms;
    give_up("simulation ran past its time limit");
  end

endmodule
